// ==== logic/tagePkg.sv ====
package tagePkg;

    localparam int PcWidth   = 32;
    localparam int PcShift   = 3;   // instruction alignment bits dropped before hashing
    localparam int GhrWidth  = 32;
    localparam int CtrWidth  = 2;
    localparam int NumTagged = 3;
    localparam int BankWidth = 2;   // bank 0 is the base table

    typedef logic [CtrWidth-1:0]  ctr_t;     // top bit is the direction
    typedef logic [BankWidth-1:0] bankId_t;

    typedef struct packed {
        logic [PcWidth-1:0] pc;
        logic               isBranch;
    } predReq_t;

    typedef struct packed {
        logic [PcWidth-1:0]  pc;
        logic [GhrWidth-1:0] ghr;       // history used for the lookup
        logic                taken;
        ctr_t                ctr;
        bankId_t             bank;
        logic                altTaken;
        ctr_t                altCtr;
        bankId_t             altBank;
    } predResp_t;

    typedef struct packed {
        logic [PcWidth-1:0]  pc;
        logic [GhrWidth-1:0] ghr;       // history current at the request
        bankId_t             bank;      // provider
        ctr_t                ctr;       // provider counter as predicted
        bankId_t             altBank;
        logic                taken;     // resolved outcome
    } updReq_t;

    typedef struct packed {
        logic hit;
        ctr_t ctr;
    } tableRead_t;

    // entry allocation on a mispredict, bank 0 means none
    typedef struct packed {
        bankId_t bank;
        ctr_t    ctr;
    } allocCmd_t;

    typedef struct packed {
        logic [PcWidth-1:0]  pc;
        logic [GhrWidth-1:0] ghr;
        ctr_t                ctr;       // trained provider counter
        allocCmd_t           alloc;
    } tableWrite_t;

    // xor of consecutive width-bit slices of the low len bits, last slice zero-extended
    function automatic logic [PcWidth-1:0] fold(input logic [PcWidth-1:0] value,
                                                input int unsigned len,
                                                input int unsigned width);
        logic [PcWidth-1:0] res;
        res = '0;
        for (int unsigned i = 0; i < PcWidth; i++) begin
            if (i < len) begin
                res[i % width] ^= value[i];
            end
        end
        return res;
    endfunction

endpackage

// ==== logic/baseTable.sv ====
module baseTable #(
    parameter int IndexBits = 7
) (
    input  logic                        Clk,
    input  logic                        arstN,
    input  logic [tagePkg::PcWidth-1:0] lookupPc,
    input  tagePkg::tableWrite_t        wrCmd,
    input  logic                        write,
    output tagePkg::ctr_t               ctr
);
    import tagePkg::*;

    localparam int Depth = 1 << IndexBits;

    ctr_t                 counters [Depth];
    logic [IndexBits-1:0] rdIdx;
    logic [IndexBits-1:0] wrIdx;
    logic [PcWidth-1:0]   rdFold;
    logic [PcWidth-1:0]   wrFold;

    assign rdFold = fold(lookupPc >> PcShift, PcWidth - PcShift, IndexBits);
    assign wrFold = fold(wrCmd.pc >> PcShift, PcWidth - PcShift, IndexBits);
    assign rdIdx  = rdFold[IndexBits-1:0];
    assign wrIdx  = wrFold[IndexBits-1:0];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < Depth; i++) begin
                counters[i] <= ctr_t'(1);   // weakly not taken
            end
        end else if (write) begin
            counters[wrIdx] <= wrCmd.ctr;
        end
    end

    always_ff @(posedge Clk) begin
        ctr <= counters[rdIdx];
    end

endmodule

// ==== logic/tageTable.sv ====
module tageTable #(
    parameter int IndexBits = 7,
    parameter int TagBits   = 7,
    parameter int HistLen   = 4,
    parameter int Bank      = 1
) (
    input  logic                         Clk,
    input  logic                         arstN,
    input  logic [tagePkg::PcWidth-1:0]  lookupPc,
    input  logic [tagePkg::GhrWidth-1:0] lookupGhr,
    input  tagePkg::tableWrite_t         wrCmd,
    input  logic                         write,
    output tagePkg::tableRead_t          rd
);
    import tagePkg::*;

    localparam int Depth = 1 << IndexBits;

    typedef struct packed {
        logic [TagBits-1:0] tag;
        ctr_t               ctr;
    } entry_t;

    logic [Depth-1:0]   validBits;
    entry_t             entries [Depth];
    logic [IndexBits-1:0] rdIdx;
    logic [TagBits-1:0]   rdTag;
    logic [IndexBits-1:0] wrIdx;
    logic [TagBits-1:0]   wrTag;
    logic                 rdValid;
    entry_t               rdEntry;
    logic [TagBits-1:0]   tagReg;     // tag of the lookup in flight
    logic                 allocHere;

    function automatic logic [IndexBits-1:0] hashIndex(input logic [PcWidth-1:0] pc,
                                                       input logic [GhrWidth-1:0] hist);
        logic [PcWidth-1:0] mix;
        mix = fold(pc >> PcShift, PcWidth - PcShift, IndexBits) ^ fold(hist, HistLen, IndexBits);
        return mix[IndexBits-1:0];
    endfunction

    function automatic logic [TagBits-1:0] hashTag(input logic [PcWidth-1:0] pc);
        logic [PcWidth-1:0] mix;
        mix = fold(pc >> PcShift, PcWidth - PcShift, TagBits) ^ PcWidth'(Bank);
        return mix[TagBits-1:0];
    endfunction

    assign rdIdx     = hashIndex(lookupPc, lookupGhr);
    assign rdTag     = hashTag(lookupPc);
    assign wrIdx     = hashIndex(wrCmd.pc, wrCmd.ghr);
    assign wrTag     = hashTag(wrCmd.pc);
    assign allocHere = wrCmd.alloc.bank == Bank;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            validBits <= '0;
            rdValid   <= 1'b0;
        end else begin
            rdValid <= validBits[rdIdx];    // old contents on a same-cycle write
            if (write && allocHere) begin
                validBits[wrIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        rdEntry <= entries[rdIdx];
        tagReg  <= rdTag;
        if (write) begin
            if (allocHere) begin
                entries[wrIdx] <= '{tag: wrTag, ctr: wrCmd.alloc.ctr};
            end else begin
                entries[wrIdx].ctr <= wrCmd.ctr;   // training keeps the tag
            end
        end
    end

    assign rd.hit = rdValid && (rdEntry.tag == tagReg);
    assign rd.ctr = rdEntry.ctr;

    // a longer table that already matched would have been the provider
    assert property (@(posedge Clk) disable iff (!arstN)
        (write && allocHere) |-> !(validBits[wrIdx] && entries[wrIdx].tag == wrTag));

endmodule

// ==== logic/providerSelect.sv ====
module providerSelect (
    input  tagePkg::tableRead_t [tagePkg::NumTagged-1:0] rd,
    input  tagePkg::ctr_t                                baseCtr,
    output tagePkg::predResp_t                           sel
);
    import tagePkg::*;

    // scan upward so each new hit pushes the previous provider down to alternate
    always_comb begin
        sel        = '0;
        sel.ctr    = baseCtr;
        sel.altCtr = baseCtr;
        for (int b = 1; b <= NumTagged; b++) begin
            if (rd[b-1].hit) begin
                sel.altBank = sel.bank;
                sel.altCtr  = sel.ctr;
                sel.bank    = bankId_t'(b);
                sel.ctr     = rd[b-1].ctr;
            end
        end
        sel.taken    = sel.ctr[CtrWidth-1];
        sel.altTaken = sel.altCtr[CtrWidth-1];
    end

endmodule

// ==== logic/tageCtrl.sv ====
module tageCtrl (
    input  logic                          Clk,
    input  logic                          arstN,
    input  logic                          reqValid,
    input  tagePkg::predReq_t             req,
    input  logic                          updValid,
    input  tagePkg::updReq_t              upd,
    input  tagePkg::predResp_t            sel,
    output logic [tagePkg::PcWidth-1:0]   lookupPc,
    output logic [tagePkg::GhrWidth-1:0]  lookupGhr,
    output tagePkg::tableWrite_t          wrCmd,
    output logic                          baseWrite,
    output logic [tagePkg::NumTagged-1:0] tableWrite,
    output logic                          respValid,
    output tagePkg::predResp_t            resp
);
    import tagePkg::*;

    logic [GhrWidth-1:0] ghr;
    logic                v1;          // table read in progress
    logic [PcWidth-1:0]  pc1;
    logic [GhrWidth-1:0] ghr1;
    logic                br1;
    logic                respBranch;
    ctr_t                stepCtr;
    logic                mispredict;
    logic                doAlloc;
    bankId_t             allocBank;

    assign lookupPc  = req.pc;
    assign lookupGhr = ghr;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            ghr <= '0;
        end else if (updValid) begin
            ghr <= upd.ghr;                              // repair from the update record
        end else if (respValid && respBranch) begin
            ghr <= {ghr[GhrWidth-2:0], resp.taken};      // newest outcome in bit 0
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            v1         <= 1'b0;
            respValid  <= 1'b0;
            respBranch <= 1'b0;
        end else begin
            v1         <= reqValid;
            respValid  <= v1;
            respBranch <= v1 && br1;
        end
    end

    always_ff @(posedge Clk) begin
        pc1  <= req.pc;
        ghr1 <= ghr;
        br1  <= req.isBranch;
        if (v1) begin
            resp     <= sel;
            resp.pc  <= pc1;
            resp.ghr <= ghr1;
        end
    end

    // saturating step toward the resolved direction
    always_comb begin
        stepCtr = upd.ctr;
        if (upd.taken && upd.ctr != '1) begin
            stepCtr = upd.ctr + 1'b1;
        end else if (!upd.taken && upd.ctr != '0) begin
            stepCtr = upd.ctr - 1'b1;
        end
    end

    assign mispredict = upd.ctr[CtrWidth-1] != upd.taken;
    assign doAlloc    = mispredict && (upd.bank < NumTagged);
    assign allocBank  = doAlloc ? bankId_t'(upd.bank + 1'b1) : '0;

    always_comb begin
        wrCmd.pc        = upd.pc;
        wrCmd.ghr       = upd.ghr;
        wrCmd.ctr       = stepCtr;
        wrCmd.alloc.bank = allocBank;
        wrCmd.alloc.ctr  = upd.taken ? ctr_t'(2) : ctr_t'(1);   // weak in the new direction
    end

    assign baseWrite = updValid && (upd.bank == '0);

    always_comb begin
        for (int b = 1; b <= NumTagged; b++) begin
            tableWrite[b-1] = updValid && ((upd.bank == b) || (allocBank == b));
        end
    end

    // the alternate always sits below a tagged provider
    assert property (@(posedge Clk) disable iff (!arstN)
        updValid |-> (upd.bank == '0 || upd.altBank < upd.bank));

endmodule

// ==== logic/tageTop.sv ====
module tageTop #(
    parameter int BaseIndexBits = 7,
    parameter int IndexBits1    = 7,
    parameter int IndexBits2    = 7,
    parameter int IndexBits3    = 8,
    parameter int TagBits1      = 7,
    parameter int TagBits2      = 8,
    parameter int TagBits3      = 9,
    parameter int HistLen1      = 4,
    parameter int HistLen2      = 12,
    parameter int HistLen3      = 32
) (
    input  logic                Clk,
    input  logic                arstN,
    input  logic                reqValid,
    input  tagePkg::predReq_t   req,
    input  logic                updValid,
    input  tagePkg::updReq_t    upd,
    output logic                respValid,
    output tagePkg::predResp_t  resp
);
    import tagePkg::*;

    logic [PcWidth-1:0]              lookupPc;
    logic [GhrWidth-1:0]             lookupGhr;
    tableWrite_t                     wrCmd;
    logic                            baseWrite;
    logic [NumTagged-1:0]            tableWrite;
    tableRead_t [NumTagged-1:0]      rd;
    ctr_t                            baseCtr;
    predResp_t                       sel;

    tageCtrl ctrl (
        .Clk(Clk), .arstN(arstN),
        .reqValid(reqValid), .req(req),
        .updValid(updValid), .upd(upd),
        .sel(sel),
        .lookupPc(lookupPc), .lookupGhr(lookupGhr),
        .wrCmd(wrCmd), .baseWrite(baseWrite), .tableWrite(tableWrite),
        .respValid(respValid), .resp(resp)
    );

    baseTable #(.IndexBits(BaseIndexBits)) baseTbl (
        .Clk(Clk), .arstN(arstN), .lookupPc(lookupPc),
        .wrCmd(wrCmd), .write(baseWrite), .ctr(baseCtr)
    );

    tageTable #(.IndexBits(IndexBits1), .TagBits(TagBits1), .HistLen(HistLen1), .Bank(1)) tbl1 (
        .Clk(Clk), .arstN(arstN), .lookupPc(lookupPc), .lookupGhr(lookupGhr),
        .wrCmd(wrCmd), .write(tableWrite[0]), .rd(rd[0])
    );

    tageTable #(.IndexBits(IndexBits2), .TagBits(TagBits2), .HistLen(HistLen2), .Bank(2)) tbl2 (
        .Clk(Clk), .arstN(arstN), .lookupPc(lookupPc), .lookupGhr(lookupGhr),
        .wrCmd(wrCmd), .write(tableWrite[1]), .rd(rd[1])
    );

    tageTable #(.IndexBits(IndexBits3), .TagBits(TagBits3), .HistLen(HistLen3), .Bank(3)) tbl3 (
        .Clk(Clk), .arstN(arstN), .lookupPc(lookupPc), .lookupGhr(lookupGhr),
        .wrCmd(wrCmd), .write(tableWrite[2]), .rd(rd[2])
    );

    providerSelect selector (
        .rd(rd),
        .baseCtr(baseCtr),
        .sel(sel)
    );

endmodule

// ==== testbench/tageTb.sv ====
module tageTb;
    import tagePkg::*;

    localparam int Timeout = 20;

    logic        Clk;
    logic        arstN;
    logic        reqValid;
    predReq_t    req;
    logic        updValid;
    updReq_t     upd;
    logic        respValid;
    predResp_t   resp;
    int          errCount;
    int          checkCount;
    int          testCount;
    int          testErrs;
    int          cycle;
    string       testName;
    logic [31:0] ghrModel;      // expected global history
    logic [31:0] usedPcs[$];

    tageTop dut (.Clk(Clk), .arstN(arstN), .reqValid(reqValid), .req(req),
                 .updValid(updValid), .upd(upd), .respValid(respValid), .resp(resp));

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;
    end

    task automatic step();
        @(posedge Clk);
        #5;                     // drive and sample away from the edge
        cycle++;
    endtask

    // xor of the width-bit slices of pc >> PcShift
    function automatic logic [31:0] pcFold(input logic [31:0] pc, input int width);
        logic [31:0] word;
        logic [31:0] res;
        word = pc >> PcShift;
        res  = '0;
        for (int s = 0; s < 32 - PcShift; s += width) begin
            res ^= (word >> s) & ((32'd1 << width) - 1);
        end
        return res;
    endfunction

    // random PC sharing no base index or tag with earlier ones
    function automatic logic [31:0] freshPc();
        logic [31:0] pc;
        bit          clash;
        int          tries;
        tries = 0;
        do begin
            pc    = $urandom();
            clash = 1'b0;
            foreach (usedPcs[i]) begin
                if (pcFold(pc, 7) == pcFold(usedPcs[i], 7)
                    || pcFold(pc, 8) == pcFold(usedPcs[i], 8)
                    || pcFold(pc, 9) == pcFold(usedPcs[i], 9)) begin
                    clash = 1'b1;
                end
            end
            tries++;
        end while (clash && tries < 1000);
        usedPcs.push_back(pc);
        return pc;
    endfunction

    task automatic checkVal(input string what, input logic [63:0] exp, input logic [63:0] act);
        checkCount++;
        assert (exp === act) else begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", testName, what, exp, act);
            testErrs++;
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrs = 0;
        testCount++;
    endtask

    task automatic endTest();
        $display("test %s: %s, %0d error(s)", testName,
                 testErrs == 0 ? "ok" : "failed", testErrs);
        errCount += testErrs;
    endtask

    task automatic sendUpdate(input logic [31:0] pc, input logic [31:0] ghr, input bankId_t bank,
                              input ctr_t ctr, input logic taken);
        upd      = '{pc: pc, ghr: ghr, bank: bank, ctr: ctr, altBank: 2'd0, taken: taken};
        updValid = 1'b1;
        step();
        updValid = 1'b0;
        ghrModel = ghr;         // history reloads from the record
    endtask

    task automatic lookup(input logic [31:0] pc, input logic isBranch, input logic expTaken,
                          output predResp_t r);
        int lat;
        req      = '{pc: pc, isBranch: isBranch};
        reqValid = 1'b1;
        step();
        reqValid = 1'b0;
        lat      = 1;
        while (!respValid && lat < Timeout) begin
            step();
            lat++;
        end
        checkCount++;
        assert (respValid) else begin
            $display("no response for PC %08h within %0d cycles in test %s", pc, Timeout, testName);
            testErrs++;
        end
        r = resp;
        checkVal("latency", 2, lat);
        checkVal("pc", pc, r.pc);
        checkVal("ghr", ghrModel, r.ghr);
        checkVal("taken", expTaken, r.taken);
        if (isBranch) begin
            ghrModel = {ghrModel[30:0], expTaken};
        end
        step();                 // let the history shift land before the next lookup
    endtask

    task automatic resetLookup();
        predResp_t r;
        startTest("reset");
        lookup(freshPc(), 1'b0, 1'b0, r);
        checkVal("bank", 0, r.bank);
        checkVal("ctr", 1, r.ctr);
        checkVal("altBank", 0, r.altBank);
        endTest();
    endtask

    task automatic trainBase(output logic [31:0] pc);
        predResp_t r;
        startTest("baseTrain");
        pc = freshPc();
        sendUpdate(pc, 32'h5, 2'd0, 2'd1, 1'b1);    // also allocates bank 1 under history 5
        sendUpdate(pc, 32'h0, 2'd0, 2'd2, 1'b1);
        lookup(pc, 1'b0, 1'b1, r);
        checkVal("bank", 0, r.bank);
        checkVal("ctr", 3, r.ctr);
        checkVal("altBank", 0, r.altBank);
        checkVal("altCtr", 3, r.altCtr);
        endTest();
    endtask

    task automatic allocateChain();
        predResp_t   r;
        logic [31:0] pc;
        startTest("allocate");
        pc = freshPc();
        sendUpdate(pc, 32'hC3, 2'd0, 2'd1, 1'b1);   // base 1 to 2 and bank 1 gets 2
        lookup(pc, 1'b0, 1'b1, r);
        checkVal("bank", 1, r.bank);
        checkVal("ctr", 2, r.ctr);
        checkVal("altBank", 0, r.altBank);
        checkVal("altCtr", 2, r.altCtr);
        sendUpdate(pc, 32'hC3, 2'd1, 2'd2, 1'b0);   // bank 1 to 1 and bank 2 gets 1
        lookup(pc, 1'b0, 1'b0, r);
        checkVal("bank", 2, r.bank);
        checkVal("ctr", 1, r.ctr);
        checkVal("altBank", 1, r.altBank);
        checkVal("altCtr", 1, r.altCtr);
        checkVal("altTaken", 0, r.altTaken);
        endTest();
    endtask

    task automatic followHistory(input logic [31:0] pcTaken);
        predResp_t   r;
        logic [31:0] pcNotTaken;
        startTest("history");
        pcNotTaken = freshPc();
        sendUpdate(pcNotTaken, 32'h8421_36C5, 2'd0, 2'd0, 1'b0);
        lookup(pcTaken, 1'b1, 1'b1, r);
        lookup(pcNotTaken, 1'b0, 1'b0, r);      // non-branch keeps history
        lookup(pcNotTaken, 1'b1, 1'b0, r);
        lookup(pcTaken, 1'b0, 1'b1, r);
        endTest();
    endtask

    task automatic backToBack();
        logic [31:0] pcs[3];
        logic [31:0] gotPc[$];
        int          gotCycle[$];
        int          waited;
        int          startCycle;
        startTest("pipeline");
        foreach (pcs[i]) begin
            pcs[i] = freshPc();
        end
        startCycle = cycle;
        for (int i = 0; i < 3; i++) begin
            req      = '{pc: pcs[i], isBranch: 1'b0};
            reqValid = 1'b1;
            step();
            if (respValid) begin
                gotPc.push_back(resp.pc);
                gotCycle.push_back(cycle);
            end
        end
        reqValid = 1'b0;
        waited   = 0;
        while (gotPc.size() < 3 && waited < Timeout) begin
            step();
            waited++;
            if (respValid) begin
                gotPc.push_back(resp.pc);
                gotCycle.push_back(cycle);
            end
        end
        checkCount++;
        assert (gotPc.size() == 3) else begin
            $display("only %0d of 3 responses arrived in test %s", gotPc.size(), testName);
            testErrs++;
        end
        for (int i = 0; i < gotPc.size() && i < 3; i++) begin
            checkVal($sformatf("resp %0d pc", i), pcs[i], gotPc[i]);
            checkVal($sformatf("resp %0d cycle", i), startCycle + 2 + i, gotCycle[i]);
        end
        endTest();
    endtask

    initial begin
        logic [31:0] pcTrained;
        void'($urandom(33));
        arstN      = 1'b0;
        reqValid   = 1'b0;
        req        = '0;
        updValid   = 1'b0;
        upd        = '0;
        errCount   = 0;
        checkCount = 0;
        testCount  = 0;
        cycle      = 0;
        ghrModel   = '0;
        repeat (10) @(posedge Clk);
        #5;
        arstN = 1'b1;
        step();
        resetLookup();
        trainBase(pcTrained);
        allocateChain();
        followHistory(pcTrained);
        backToBack();
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== tage.f ====
logic/tagePkg.sv
logic/baseTable.sv
logic/tageTable.sv
logic/providerSelect.sv
logic/tageCtrl.sv
logic/tageTop.sv
testbench/tageTb.sv

// ==== Bender.yml ====
package:
  name: tage

sources:
  - logic/tagePkg.sv
  - logic/baseTable.sv
  - logic/tageTable.sv
  - logic/providerSelect.sv
  - logic/tageCtrl.sv
  - logic/tageTop.sv
  - target: test
    files:
      - testbench/tageTb.sv
